// ==== logic/cmp_mem_pkg.sv ====
// memory side of the engine; one 64-bit word per read, pages are 4 KB and way-aligned
package cmp_mem_pkg;

    // byte address on the memory port
    typedef logic [47:0] addr_t;
    // way number, the page-aligned part of an address (bits 47:12)
    typedef logic [35:0] way_t;
    // one memory data word
    typedef logic [63:0] word_t;

    // page geometry
    localparam int unsigned PAGE_BYTES = 4096;
    localparam int unsigned WORD_BYTES = 8;
    localparam int unsigned PAGE_WORDS = 512;
    typedef logic [8:0] word_idx_t;

    // uncompressed-page list, one 8-byte entry per index
    localparam addr_t LIST_BASE = 48'h0000_4000_0000;
    typedef logic [15:0] list_idx_t;

    // list entry as it sits in the low 64 bits of the word read
    typedef struct packed {
        logic        valid;
        logic [26:0] rsvd;
        way_t        way;
    } list_entry_t;

    // read response, err set on a bus error
    typedef struct packed {
        word_t data;
        logic  err;
    } mem_rsp_t;

endpackage

// ==== logic/cmp_ctrl_pkg.sv ====
// controller side; sizes are byte counts from zero-word elimination, 8 size classes of 512 B
package cmp_ctrl_pkg;

    // compressed size in bytes, up to 64 + 512 * 8
    typedef logic [12:0] cmp_size_t;
    // byte fill level inside a zspage, up to 4096
    typedef logic [12:0] fill_t;
    // size class, size / 512 saturated at 7
    typedef logic [2:0] class_t;

    localparam int unsigned ZS_MD_SIZE      = 64;
    localparam int unsigned BITMAP_BYTES    = 64;
    // larger pages cannot share a way with the zspage metadata
    localparam int unsigned MAX_SHARED_SIZE = 4032;
    localparam int unsigned CLASS_COUNT     = 8;

    typedef enum logic [2:0] {
        PLACED_SHARED,
        OPENED_NEW,
        INCOMPRESSIBLE,
        LIST_INVALID,
        BUS_ERROR
    } place_status_t;

    // result returned with cmd_ack
    typedef struct packed {
        place_status_t     status;
        cmp_size_t         size;
        class_t            cls;
        cmp_mem_pkg::way_t zs_way;
        fill_t             offset;
        cmp_mem_pkg::way_t freed_way;
    } cmp_result_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_ENTRY,
        SCAN_PAGE,
        PLACE,
        RESPOND,
        RELEASE
    } ctrl_state_t;

endpackage

// ==== logic/cmp_list_reader.sv ====
// single-beat four-phase read master; rd_start is ignored while a read is in flight
`timescale 1ns/10ps
module cmp_list_reader (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // request side, from the controller
    input  logic                  rd_start,
    input  cmp_mem_pkg::addr_t    rd_addr,
    output logic                  rd_done,
    output cmp_mem_pkg::mem_rsp_t rd_rsp,
    // memory port
    output logic                  mem_req,
    output cmp_mem_pkg::addr_t    mem_addr,
    input  logic                  mem_ack,
    input  cmp_mem_pkg::mem_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT_ACK,
        RD_WAIT_DROP
    } rd_state_t;

    rd_state_t state;

    // handshake sequencing
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state   <= RD_IDLE;
            mem_req <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (rd_start) begin
                        mem_req <= 1'b1;
                        state   <= RD_WAIT_ACK;
                    end
                end
                RD_WAIT_ACK: begin
                    // slave holds mem_rsp valid with the ack
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= RD_WAIT_DROP;
                    end
                end
                RD_WAIT_DROP: begin
                    // done only once the slave has let go of ack
                    if (!mem_ack) begin
                        rd_done <= 1'b1;
                        state   <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // address stays put for the whole request, response held until the next capture
    always_ff @(posedge clk_i) begin
        if (state == RD_IDLE && rd_start) begin
            mem_addr <= rd_addr;
        end
        if (state == RD_WAIT_ACK && mem_ack) begin
            rd_rsp <= mem_rsp;
        end
    end

endmodule

// ==== logic/cmp_size_estimator.sv ====
// size valid the cycle after the last word_valid; clear wins over a word in the same cycle
`timescale 1ns/10ps
module cmp_size_estimator (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    clear,
    input  logic                    word_valid,
    input  cmp_mem_pkg::word_t      word,
    output cmp_ctrl_pkg::cmp_size_t est_size,
    output cmp_ctrl_pkg::class_t    est_class
);

    // nonzero words seen, 0 to 512
    logic [9:0] nz_count;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nz_count <= '0;
        end else if (clear) begin
            nz_count <= '0;
        end else if (word_valid && (word != '0)) begin
            nz_count <= nz_count + 10'd1;
        end
    end

    // presence bitmap plus eight bytes per stored word
    assign est_size = cmp_ctrl_pkg::cmp_size_t'(cmp_ctrl_pkg::BITMAP_BYTES)
                    + cmp_ctrl_pkg::cmp_size_t'({nz_count, 3'b000});

    // size / 512 saturated at 7 once bit 12 is set
    assign est_class = est_size[12] ? cmp_ctrl_pkg::class_t'(3'd7)
                                    : cmp_ctrl_pkg::class_t'(est_size[11:9]);

endmodule

// ==== logic/cmp_zspage_table.sv ====
// one open zspage per class; a page that does not fit replaces the entry, the old one is dropped
`timescale 1ns/10ps
module cmp_zspage_table (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    place_req,
    input  cmp_mem_pkg::way_t       page_way,
    input  cmp_ctrl_pkg::cmp_size_t place_size,
    input  cmp_ctrl_pkg::class_t    place_class,
    output logic                    place_done,
    output logic                    place_shared,
    output cmp_mem_pkg::way_t       zs_way,
    output cmp_ctrl_pkg::fill_t     zs_offset
);

    logic                zs_valid [cmp_ctrl_pkg::CLASS_COUNT];
    cmp_mem_pkg::way_t   zs_base  [cmp_ctrl_pkg::CLASS_COUNT];
    cmp_ctrl_pkg::fill_t zs_fill  [cmp_ctrl_pkg::CLASS_COUNT];

    // one extra bit so the sum cannot wrap
    logic [13:0] new_fill;
    logic        fits;

    assign new_fill = {1'b0, zs_fill[place_class]} + {1'b0, place_size};
    assign fits     = zs_valid[place_class]
                   && (new_fill <= 14'(cmp_mem_pkg::PAGE_BYTES));

    // valid bits and the done pulse
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            place_done <= 1'b0;
            for (int i = 0; i < cmp_ctrl_pkg::CLASS_COUNT; i++) begin
                zs_valid[i] <= 1'b0;
            end
        end else begin
            place_done <= place_req;
            if (place_req) begin
                zs_valid[place_class] <= 1'b1;
            end
        end
    end

    // base, fill and the placement answer
    always_ff @(posedge clk_i) begin
        if (place_req) begin
            if (fits) begin
                // page goes after the current fill of the open zspage
                place_shared         <= 1'b1;
                zs_way               <= zs_base[place_class];
                zs_offset            <= zs_fill[place_class];
                zs_fill[place_class] <= new_fill[12:0];
            end else begin
                // page's own way becomes the new zspage, metadata first
                place_shared         <= 1'b0;
                zs_way               <= page_way;
                zs_offset            <= cmp_ctrl_pkg::fill_t'(cmp_ctrl_pkg::ZS_MD_SIZE);
                zs_base[place_class] <= page_way;
                zs_fill[place_class] <= cmp_ctrl_pkg::fill_t'(cmp_ctrl_pkg::ZS_MD_SIZE)
                                      + place_size;
            end
        end
    end

endmodule

// ==== logic/cmp_mngr_ctrl.sv ====
// one command at a time; an error ends only that command, the next one starts clean
`timescale 1ns/10ps
module cmp_mngr_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // command port
    input  logic                      cmd_req,
    input  cmp_mem_pkg::list_idx_t    cmd_idx,
    output logic                      cmd_ack,
    output cmp_ctrl_pkg::cmp_result_t cmd_result,
    // list reader
    output logic                      rd_start,
    output cmp_mem_pkg::addr_t        rd_addr,
    input  logic                      rd_done,
    input  cmp_mem_pkg::mem_rsp_t     rd_rsp,
    // size estimator
    output logic                      clear,
    output logic                      word_valid,
    input  cmp_ctrl_pkg::cmp_size_t   est_size,
    input  cmp_ctrl_pkg::class_t      est_class,
    // zspage table
    output logic                      place_req,
    output cmp_mem_pkg::way_t         page_way,
    input  logic                      place_done,
    input  logic                      place_shared,
    input  cmp_mem_pkg::way_t         zs_way,
    input  cmp_ctrl_pkg::fill_t       zs_offset
);

    cmp_ctrl_pkg::ctrl_state_t state;
    cmp_mem_pkg::word_idx_t    word_idx;
    cmp_mem_pkg::list_entry_t  entry;

    assign entry = cmp_mem_pkg::list_entry_t'(rd_rsp.data);

    // estimator counts straight off the reader's response
    assign word_valid = (state == cmp_ctrl_pkg::SCAN_PAGE) && rd_done && !rd_rsp.err;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state      <= cmp_ctrl_pkg::IDLE;
            cmd_ack    <= 1'b0;
            cmd_result <= '0;
            rd_start   <= 1'b0;
            rd_addr    <= '0;
            clear      <= 1'b0;
            place_req  <= 1'b0;
            page_way   <= '0;
            word_idx   <= '0;
        end else begin
            // single-cycle strobes
            rd_start  <= 1'b0;
            clear     <= 1'b0;
            place_req <= 1'b0;
            case (state)
                cmp_ctrl_pkg::IDLE: begin
                    if (cmd_req) begin
                        cmd_result <= '0;
                        rd_addr    <= cmp_mem_pkg::LIST_BASE
                                    + cmp_mem_pkg::addr_t'({cmd_idx, 3'b000});
                        rd_start   <= 1'b1;
                        state      <= cmp_ctrl_pkg::READ_ENTRY;
                    end
                end
                cmp_ctrl_pkg::READ_ENTRY: begin
                    if (rd_done) begin
                        if (rd_rsp.err) begin
                            cmd_result.status <= cmp_ctrl_pkg::BUS_ERROR;
                            state             <= cmp_ctrl_pkg::RESPOND;
                        end else if (!entry.valid) begin
                            cmd_result.status <= cmp_ctrl_pkg::LIST_INVALID;
                            state             <= cmp_ctrl_pkg::RESPOND;
                        end else begin
                            // start the page scan at word 0 of the way
                            page_way <= entry.way;
                            rd_addr  <= {entry.way, 12'h000};
                            rd_start <= 1'b1;
                            clear    <= 1'b1;
                            word_idx <= '0;
                            state    <= cmp_ctrl_pkg::SCAN_PAGE;
                        end
                    end
                end
                cmp_ctrl_pkg::SCAN_PAGE: begin
                    if (rd_done) begin
                        if (rd_rsp.err) begin
                            cmd_result.status <= cmp_ctrl_pkg::BUS_ERROR;
                            state             <= cmp_ctrl_pkg::RESPOND;
                        end else if (word_idx ==
                                     cmp_mem_pkg::word_idx_t'(cmp_mem_pkg::PAGE_WORDS - 1)) begin
                            // last word counted this cycle, size settles next cycle
                            state <= cmp_ctrl_pkg::PLACE;
                        end else begin
                            word_idx <= word_idx + 9'd1;
                            rd_addr  <= rd_addr
                                      + cmp_mem_pkg::addr_t'(cmp_mem_pkg::WORD_BYTES);
                            rd_start <= 1'b1;
                        end
                    end
                end
                cmp_ctrl_pkg::PLACE: begin
                    if (place_done) begin
                        cmd_result.zs_way <= zs_way;
                        cmd_result.offset <= zs_offset;
                        if (place_shared) begin
                            // page moved into an open zspage, its way is free
                            cmd_result.status    <= cmp_ctrl_pkg::PLACED_SHARED;
                            cmd_result.freed_way <= page_way;
                        end else begin
                            cmd_result.status <= cmp_ctrl_pkg::OPENED_NEW;
                        end
                        state <= cmp_ctrl_pkg::RESPOND;
                    end else if (!place_req) begin
                        // first cycle here, place_req still high means wait for done
                        cmd_result.size <= est_size;
                        cmd_result.cls  <= est_class;
                        if (est_size > cmp_ctrl_pkg::cmp_size_t'(cmp_ctrl_pkg::MAX_SHARED_SIZE)) begin
                            cmd_result.status <= cmp_ctrl_pkg::INCOMPRESSIBLE;
                            state             <= cmp_ctrl_pkg::RESPOND;
                        end else begin
                            place_req <= 1'b1;
                        end
                    end
                end
                cmp_ctrl_pkg::RESPOND: begin
                    // result is final here and held until the ack drops
                    cmd_ack <= 1'b1;
                    state   <= cmp_ctrl_pkg::RELEASE;
                end
                cmp_ctrl_pkg::RELEASE: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= cmp_ctrl_pkg::IDLE;
                    end
                end
                default: state <= cmp_ctrl_pkg::IDLE;
            endcase
        end
    end

endmodule

// ==== logic/cmp_subsys_top.sv ====
// compaction engine top; no write-back, the result reports placement only
`timescale 1ns/10ps
module cmp_subsys_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // command port, four-phase
    input  logic                      cmd_req,
    input  cmp_mem_pkg::list_idx_t    cmd_idx,
    output logic                      cmd_ack,
    output cmp_ctrl_pkg::cmp_result_t cmd_result,
    // memory port, four-phase single word reads
    output logic                      mem_req,
    output cmp_mem_pkg::addr_t        mem_addr,
    input  logic                      mem_ack,
    input  cmp_mem_pkg::mem_rsp_t     mem_rsp
);

    // controller to reader
    logic                    rd_start;
    logic                    rd_done;
    cmp_mem_pkg::addr_t      rd_addr;
    cmp_mem_pkg::mem_rsp_t   rd_rsp;
    // controller to estimator
    logic                    clear;
    logic                    word_valid;
    cmp_ctrl_pkg::cmp_size_t est_size;
    cmp_ctrl_pkg::class_t    est_class;
    // controller to table
    logic                    place_req;
    logic                    place_done;
    logic                    place_shared;
    cmp_mem_pkg::way_t       page_way;
    cmp_mem_pkg::way_t       zs_way;
    cmp_ctrl_pkg::fill_t     zs_offset;

    cmp_mngr_ctrl i_ctrl (
        .clk_i, .rst_ni, .cmd_req, .cmd_idx, .cmd_ack, .cmd_result,
        .rd_start, .rd_addr, .rd_done, .rd_rsp,
        .clear, .word_valid, .est_size, .est_class,
        .place_req, .page_way, .place_done, .place_shared, .zs_way, .zs_offset
    );

    cmp_list_reader i_reader (
        .clk_i, .rst_ni, .rd_start, .rd_addr, .rd_done, .rd_rsp,
        .mem_req, .mem_addr, .mem_ack, .mem_rsp
    );

    // words come from the reader's held response
    cmp_size_estimator i_estimator (
        .clk_i, .rst_ni, .clear, .word_valid,
        .word      (rd_rsp.data),
        .est_size, .est_class
    );

    cmp_zspage_table i_table (
        .clk_i, .rst_ni, .place_req, .page_way,
        .place_size  (est_size),
        .place_class (est_class),
        .place_done, .place_shared, .zs_way, .zs_offset
    );

endmodule

// ==== tests/cmp_mem_model.sv ====
// behavioral four-phase read slave; ack delay of 0 to 3 cycles from $urandom, way 20 always faults
`timescale 1ns/10ps
module cmp_mem_model (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  mem_req,
    input  cmp_mem_pkg::addr_t    mem_addr,
    output logic                  mem_ack,
    output cmp_mem_pkg::mem_rsp_t mem_rsp
);

    // list region covers all 64K entries of 8 bytes
    localparam cmp_mem_pkg::addr_t LIST_END = cmp_mem_pkg::LIST_BASE + 48'h8_0000;

    // data comes from fixed rules, nothing is stored
    function automatic cmp_mem_pkg::mem_rsp_t read_word(input cmp_mem_pkg::addr_t addr);
        cmp_mem_pkg::mem_rsp_t    rsp;
        cmp_mem_pkg::list_entry_t entry;
        longint unsigned          idx;
        longint unsigned          nz;
        rsp = '0;
        if (addr >= cmp_mem_pkg::LIST_BASE && addr < LIST_END) begin
            // entry i names way 16 + i, index 5 is a hole in the list
            idx         = 64'(addr - cmp_mem_pkg::LIST_BASE) >> 3;
            entry.valid = (idx != 64'd5);
            entry.rsvd  = '0;
            entry.way   = cmp_mem_pkg::way_t'(64'd16 + idx);
            rsp.data    = cmp_mem_pkg::word_t'(entry);
        end else begin
            // leading words of the page are nonzero, count set by the way
            nz = (64'(addr[47:12]) * 64'd37) % 64'd520;
            if (64'(addr[11:3]) < nz) begin
                rsp.data = {addr, 16'h5a5a};
            end
            rsp.err = (addr[47:12] == 36'd20);
        end
        return rsp;
    endfunction

    initial begin
        int unsigned delay;
        mem_ack = 1'b0;
        mem_rsp = '0;
        forever begin
            @(posedge clk_i);
            if (rst_ni && mem_req) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge clk_i);
                #2;
                mem_rsp = read_word(mem_addr);
                mem_ack = 1'b1;
                // hold ack until the master lets go of req
                @(posedge clk_i);
                while (mem_req) @(posedge clk_i);
                #2;
                mem_ack = 1'b0;
            end
        end
    end

endmodule

// ==== tests/tb_cmp_subsys.sv ====
// command-level testbench; fixed command list, table model starts empty like the DUT after reset
`timescale 1ns/10ps
module tb_cmp_subsys;

    localparam int unsigned SEED     = 32'h7c5d6fa2;
    localparam int unsigned NUM_CMDS = 20;
    // per word at most start, req, 3 wait, ack, drop, done and a spare, 513 reads per command
    localparam int unsigned CMD_CYCLES = 513 * 10 + 64;
    localparam int unsigned MAX_CYCLES = NUM_CMDS * CMD_CYCLES;

    logic                      clk_i = 1'b0;
    logic                      rst_ni;
    logic                      cmd_req;
    cmp_mem_pkg::list_idx_t    cmd_idx;
    logic                      cmd_ack;
    cmp_ctrl_pkg::cmp_result_t cmd_result;
    logic                      mem_req;
    cmp_mem_pkg::addr_t        mem_addr;
    logic                      mem_ack;
    cmp_mem_pkg::mem_rsp_t     mem_rsp;

    // class 1 chain until it overflows, class 2 pair, bus error, invalid entry,
    // class 5 replace, class 7 around the incompressible page, class 1 again
    int unsigned cmd_list [NUM_CMDS] = '{0, 1, 13, 14, 15, 28, 29, 2, 3, 4,
                                         6, 5, 7, 8, 9, 10, 12, 11, 0, 1};

    // reference copy of the zspage table
    logic              ref_valid [cmp_ctrl_pkg::CLASS_COUNT];
    cmp_mem_pkg::way_t ref_base  [cmp_ctrl_pkg::CLASS_COUNT];
    int unsigned       ref_fill  [cmp_ctrl_pkg::CLASS_COUNT];

    int unsigned value_errors     = 0;
    int unsigned handshake_errors = 0;
    int unsigned cycles           = 0;

    cmp_subsys_top i_dut (
        .clk_i, .rst_ni, .cmd_req, .cmd_idx, .cmd_ack, .cmd_result,
        .mem_req, .mem_addr, .mem_ack, .mem_rsp
    );

    cmp_mem_model i_mem (
        .clk_i, .rst_ni, .mem_req, .mem_addr, .mem_ack, .mem_rsp
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped: %0d cycles passed and the commands did not finish", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input int unsigned idx, input string field,
                                   input longint unsigned got, input longint unsigned want);
        value_errors++;
        $display("** Error @ %0t: index %0d %s got %0h expected %0h",
                 $time, idx, field, got, want);
    endtask

    task automatic handshake_fail(input string msg);
        handshake_errors++;
        $display("** Error @ %0t: %s", $time, msg);
    endtask

    // expected result from the memory rules and the placement rules, updates the model
    task automatic predict(input int unsigned idx, output cmp_ctrl_pkg::cmp_result_t exp);
        cmp_mem_pkg::way_t way;
        int unsigned       nz;
        int unsigned       size;
        int unsigned       cls;
        exp = '0;
        way = cmp_mem_pkg::way_t'(16 + idx);
        if (idx == 5) begin
            exp.status = cmp_ctrl_pkg::LIST_INVALID;
        end else if (way == 36'd20) begin
            exp.status = cmp_ctrl_pkg::BUS_ERROR;
        end else begin
            nz = ((16 + idx) * 37) % 520;
            if (nz > cmp_mem_pkg::PAGE_WORDS) begin
                nz = cmp_mem_pkg::PAGE_WORDS;
            end
            size      = cmp_ctrl_pkg::BITMAP_BYTES + 8 * nz;
            cls       = (size / 512 > 7) ? 7 : size / 512;
            exp.size  = cmp_ctrl_pkg::cmp_size_t'(size);
            exp.cls   = cmp_ctrl_pkg::class_t'(cls);
            if (size > cmp_ctrl_pkg::MAX_SHARED_SIZE) begin
                // table left alone
                exp.status = cmp_ctrl_pkg::INCOMPRESSIBLE;
            end else if (ref_valid[cls] && ref_fill[cls] + size <= cmp_mem_pkg::PAGE_BYTES) begin
                exp.status    = cmp_ctrl_pkg::PLACED_SHARED;
                exp.zs_way    = ref_base[cls];
                exp.offset    = cmp_ctrl_pkg::fill_t'(ref_fill[cls]);
                exp.freed_way = way;
                ref_fill[cls] = ref_fill[cls] + size;
            end else begin
                exp.status     = cmp_ctrl_pkg::OPENED_NEW;
                exp.zs_way     = way;
                exp.offset     = cmp_ctrl_pkg::fill_t'(cmp_ctrl_pkg::ZS_MD_SIZE);
                ref_valid[cls] = 1'b1;
                ref_base[cls]  = way;
                ref_fill[cls]  = cmp_ctrl_pkg::ZS_MD_SIZE + size;
            end
        end
    endtask

    task automatic check_result(input int unsigned idx, input cmp_ctrl_pkg::cmp_result_t exp);
        assert (cmd_result.status == exp.status)
            else report_mismatch(idx, "status", cmd_result.status, exp.status);
        assert (cmd_result.size == exp.size)
            else report_mismatch(idx, "size", cmd_result.size, exp.size);
        assert (cmd_result.cls == exp.cls)
            else report_mismatch(idx, "class", cmd_result.cls, exp.cls);
        assert (cmd_result.zs_way == exp.zs_way)
            else report_mismatch(idx, "zspage way", cmd_result.zs_way, exp.zs_way);
        assert (cmd_result.offset == exp.offset)
            else report_mismatch(idx, "offset", cmd_result.offset, exp.offset);
        assert (cmd_result.freed_way == exp.freed_way)
            else report_mismatch(idx, "freed way", cmd_result.freed_way, exp.freed_way);
    endtask

    task automatic run_command(input int unsigned idx);
        cmp_ctrl_pkg::cmp_result_t exp;
        int unsigned               hold;
        predict(idx, exp);
        @(posedge clk_i);
        #2;
        cmd_idx = cmp_mem_pkg::list_idx_t'(idx);
        cmd_req = 1'b1;
        @(negedge clk_i);
        while (!cmd_ack) @(negedge clk_i);
        check_result(idx, exp);
        // host keeps req up a little longer, result must not move
        hold = $urandom_range(2, 0);
        repeat (hold) @(posedge clk_i);
        @(posedge clk_i);
        #2;
        cmd_req = 1'b0;
        @(negedge clk_i);
        while (cmd_ack) @(negedge clk_i);
    endtask

    // handshake rules, sampled mid-cycle
    logic                      prev_ack     = 1'b0;
    logic                      prev_req     = 1'b0;
    logic                      prev_mem_ack = 1'b0;
    cmp_ctrl_pkg::cmp_result_t prev_result  = '0;
    cmp_mem_pkg::addr_t        prev_addr    = '0;

    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (cmd_ack && !prev_ack) begin
                assert (cmd_req) else handshake_fail("cmd_ack rose while cmd_req was low");
            end
            if (cmd_ack && prev_ack) begin
                assert (cmd_result == prev_result)
                    else handshake_fail("cmd_result changed while cmd_ack was high");
            end
            if (prev_req && !prev_mem_ack) begin
                assert (mem_req && mem_addr == prev_addr)
                    else handshake_fail("mem_req or mem_addr changed before mem_ack");
            end
        end
        prev_ack     = cmd_ack;
        prev_req     = mem_req;
        prev_mem_ack = mem_ack;
        prev_result  = cmd_result;
        prev_addr    = mem_addr;
    end

    initial begin
        void'($urandom(SEED));
        rst_ni  = 1'b0;
        cmd_req = 1'b0;
        cmd_idx = '0;
        for (int i = 0; i < cmp_ctrl_pkg::CLASS_COUNT; i++) begin
            ref_valid[i] = 1'b0;
            ref_base[i]  = '0;
            ref_fill[i]  = 0;
        end
        repeat (16) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        for (int i = 0; i < NUM_CMDS; i++) begin
            run_command(cmd_list[i]);
        end
        $display("errors: %0d in results, %0d in handshakes", value_errors, handshake_errors);
        if (value_errors + handshake_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/cmp_mem_pkg.sv
logic/cmp_ctrl_pkg.sv
logic/cmp_list_reader.sv
logic/cmp_size_estimator.sv
logic/cmp_zspage_table.sv
logic/cmp_mngr_ctrl.sv
logic/cmp_subsys_top.sv
tests/cmp_mem_model.sv
tests/tb_cmp_subsys.sv

// ==== Bender.yml ====
package:
  name: cmp_subsys

sources:
  - logic/cmp_mem_pkg.sv
  - logic/cmp_ctrl_pkg.sv
  - logic/cmp_list_reader.sv
  - logic/cmp_size_estimator.sv
  - logic/cmp_zspage_table.sv
  - logic/cmp_mngr_ctrl.sv
  - logic/cmp_subsys_top.sv
  - target: test
    files:
      - tests/cmp_mem_model.sv
      - tests/tb_cmp_subsys.sv
